// File: cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// ***********************************************************
// Datapath sizing
// ***********************************************************

// Datapath width.
`define WORD_SIZE 16

// Register file depth.
`define NUM_REGS 4

// Register address width.
`define REG_ADDR_BITS 2

// Immediate field width.
`define IMM_BITS 8

`endif

// File: isa_pkg.sv
`default_nettype none

`include "cpu_config.svh"

package isa_pkg;

    // ***********************************************************
    // Opcodes
    // ***********************************************************
    typedef enum logic [3:0] {
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_ALU_R = 4'd15
    } opcode_t;

    // R-type function codes.
    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } func_t;

    // Field overlay of one instruction word.
    // The immediate shares bits 7..0 with rd and func.
    typedef struct packed {
        opcode_t                     opcode; // 15..12
        logic [`REG_ADDR_BITS-1:0]   rs;     // 11..10
        logic [`REG_ADDR_BITS-1:0]   rt;     // 9..8
        logic [`REG_ADDR_BITS-1:0]   rd;     // 7..6
        func_t                       func;   // 5..0
    } instr_t;

endpackage

`default_nettype wire

// File: pipe_pkg.sv
`default_nettype none

`include "cpu_config.svh"

package pipe_pkg;

    // ***********************************************************
    // ALU operations
    // ***********************************************************
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_ORR = 4'd3,
        ALU_NOT = 4'd4,
        ALU_TCP = 4'd5,
        ALU_SHL = 4'd6,
        ALU_SHR = 4'd7,
        ALU_ORI = 4'd8,  // OR with zero-extended immediate.
        ALU_LHI = 4'd9   // Pass operand B.
    } alu_op_t;

    // ***********************************************************
    // Pipeline payloads
    // ***********************************************************

    // Decoded instruction, ID to EX.
    typedef struct packed {
        logic [`REG_ADDR_BITS-1:0] rs;
        logic [`REG_ADDR_BITS-1:0] rt;
        logic [`WORD_SIZE-1:0]     op_a;
        logic [`WORD_SIZE-1:0]     op_b;
        logic [`WORD_SIZE-1:0]     imm;      // Already extended.
        logic [`REG_ADDR_BITS-1:0] dest;
        alu_op_t                   alu_op;
        logic                      use_imm;
        logic                      reg_write;
        logic                      is_wwd;
        logic                      is_halt;
    } id_ex_t;

    // Executed instruction, EX to WB.
    typedef struct packed {
        logic [`WORD_SIZE-1:0]     result;
        logic [`REG_ADDR_BITS-1:0] dest;
        logic                      reg_write;
        logic                      is_wwd;
        logic                      is_halt;
    } ex_wb_t;

endpackage

`default_nettype wire

// File: instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module instr_decoder (
    input  isa_pkg::instr_t                instr,
    input  logic [`WORD_SIZE-1:0]          rdata_a,
    input  logic [`WORD_SIZE-1:0]          rdata_b,
    output logic [`REG_ADDR_BITS-1:0]      raddr_a,
    output logic [`REG_ADDR_BITS-1:0]      raddr_b,
    output pipe_pkg::id_ex_t               decoded
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic [`IMM_BITS-1:0] imm8;

    assign imm8    = instr[`IMM_BITS-1:0]; // Overlays rd and func.
    assign raddr_a = instr.rs;
    assign raddr_b = instr.rt;

    always_comb begin
        decoded           = '0;
        decoded.rs        = instr.rs;
        decoded.rt        = instr.rt;
        decoded.op_a      = rdata_a;
        decoded.op_b      = rdata_b;
        decoded.dest      = instr.rd;
        decoded.alu_op    = ALU_ADD;

        case (instr.opcode)
            OP_ALU_R: begin
                case (instr.func)
                    FN_ADD: begin decoded.alu_op = ALU_ADD; decoded.reg_write = 1'b1; end
                    FN_SUB: begin decoded.alu_op = ALU_SUB; decoded.reg_write = 1'b1; end
                    FN_AND: begin decoded.alu_op = ALU_AND; decoded.reg_write = 1'b1; end
                    FN_ORR: begin decoded.alu_op = ALU_ORR; decoded.reg_write = 1'b1; end
                    FN_NOT: begin decoded.alu_op = ALU_NOT; decoded.reg_write = 1'b1; end
                    FN_TCP: begin decoded.alu_op = ALU_TCP; decoded.reg_write = 1'b1; end
                    FN_SHL: begin decoded.alu_op = ALU_SHL; decoded.reg_write = 1'b1; end
                    FN_SHR: begin decoded.alu_op = ALU_SHR; decoded.reg_write = 1'b1; end
                    FN_WWD: decoded.is_wwd  = 1'b1;
                    FN_HLT: decoded.is_halt = 1'b1;
                    default: ;                     // Unknown func is a no-op.
                endcase
            end
            OP_ADI: begin
                decoded.alu_op    = ALU_ADD;
                decoded.use_imm   = 1'b1;
                decoded.reg_write = 1'b1;
                decoded.dest      = instr.rt;
                decoded.imm       = {{(`WORD_SIZE-`IMM_BITS){imm8[`IMM_BITS-1]}}, imm8};
            end
            OP_ORI: begin
                decoded.alu_op    = ALU_ORI;
                decoded.use_imm   = 1'b1;
                decoded.reg_write = 1'b1;
                decoded.dest      = instr.rt;
                decoded.imm       = {{(`WORD_SIZE-`IMM_BITS){1'b0}}, imm8};
            end
            OP_LHI: begin
                decoded.alu_op    = ALU_LHI;
                decoded.use_imm   = 1'b1;
                decoded.reg_write = 1'b1;
                decoded.dest      = instr.rt;
                decoded.imm       = {imm8, {(`WORD_SIZE-`IMM_BITS){1'b0}}}; // High byte.
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module reg_file (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic [`REG_ADDR_BITS-1:0]     raddr_a,
    input  logic [`REG_ADDR_BITS-1:0]     raddr_b,
    output logic [`WORD_SIZE-1:0]         rdata_a,
    output logic [`WORD_SIZE-1:0]         rdata_b,
    input  logic                          we,
    input  logic [`REG_ADDR_BITS-1:0]     waddr,
    input  logic [`WORD_SIZE-1:0]         wdata
);

    logic [`WORD_SIZE-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-through so a same-cycle reader sees the new value.
    assign rdata_a = (we && waddr == raddr_a) ? wdata : regs[raddr_a];
    assign rdata_b = (we && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule

`default_nettype wire

// File: pipe_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     load,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q,
    output logic     q_valid
);

    // Bubble wins over load.
    always_ff @(posedge clk) begin
        if (reset_n || bubble) begin
            q_valid <= 1'b0;
            q       <= '0;
        end else if (load) begin
            q_valid <= 1'b1;
            q       <= d;
        end
    end

endmodule

`default_nettype wire

// File: execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module execute_stage (
    input  logic             clk,
    input  logic             reset_n,
    input  pipe_pkg::id_ex_t id_ex,
    input  logic             id_ex_valid,
    input  pipe_pkg::ex_wb_t ex_wb,
    input  logic             ex_wb_valid,
    output pipe_pkg::ex_wb_t result,
    output logic             result_valid
);

    import pipe_pkg::*;

    logic                  wb_writes;
    logic [`WORD_SIZE-1:0] op_a;
    logic [`WORD_SIZE-1:0] fwd_b;
    logic [`WORD_SIZE-1:0] op_b;
    logic [`WORD_SIZE-1:0] alu_out;
    logic                  halted;

    // ***********************************************************
    // Forwarding from EX/WB
    // ***********************************************************
    assign wb_writes = ex_wb_valid && ex_wb.reg_write;
    assign op_a  = (wb_writes && ex_wb.dest == id_ex.rs) ? ex_wb.result : id_ex.op_a;
    assign fwd_b = (wb_writes && ex_wb.dest == id_ex.rt) ? ex_wb.result : id_ex.op_b;
    assign op_b  = id_ex.use_imm ? id_ex.imm : fwd_b;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: alu_out = op_a + op_b;
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_ORR: alu_out = op_a | op_b;
            ALU_NOT: alu_out = ~op_a;
            ALU_TCP: alu_out = ~op_a + 1'b1;
            ALU_SHL: alu_out = op_a << 1;
            ALU_SHR: alu_out = $signed(op_a) >>> 1; // Keeps the sign bit.
            ALU_ORI: alu_out = op_a | op_b;
            ALU_LHI: alu_out = op_b;
            default: alu_out = '0;
        endcase
    end

    always_comb begin
        result.result    = id_ex.is_wwd ? op_a : alu_out; // WWD outputs rs.
        result.dest      = id_ex.dest;
        result.reg_write = id_ex.reg_write;
        result.is_wwd    = id_ex.is_wwd;
        result.is_halt   = id_ex.is_halt;
    end

    // ***********************************************************
    // Halt
    // ***********************************************************
    always_ff @(posedge clk) begin
        if (reset_n) begin
            halted <= 1'b0;
        end else if (id_ex_valid && id_ex.is_halt) begin
            halted <= 1'b1;   // Sticky until reset.
        end
    end

    // The HLT itself passes; everything behind it is dropped.
    assign result_valid = id_ex_valid && !halted;

endmodule

`default_nettype wire

// File: exec_slice_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module exec_slice_top (
    input  logic                  clk,
    input  logic                  reset_n,
    input  isa_pkg::instr_t       instr,
    input  logic                  instr_valid,
    input  logic                  flush,
    output logic [`WORD_SIZE-1:0] out_port,
    output logic                  out_valid,
    output logic                  done
);

    import pipe_pkg::*;

    logic [`REG_ADDR_BITS-1:0] raddr_a;
    logic [`REG_ADDR_BITS-1:0] raddr_b;
    logic [`WORD_SIZE-1:0]     rdata_a;
    logic [`WORD_SIZE-1:0]     rdata_b;
    id_ex_t                    decoded;
    id_ex_t                    id_ex_q;
    logic                      id_ex_valid;
    ex_wb_t                    ex_result;
    logic                      ex_result_valid;
    ex_wb_t                    ex_wb_q;
    logic                      ex_wb_valid;
    logic                      wb_we;
    logic                      halt_in_wb;

    // ***********************************************************
    // Decode and register read
    // ***********************************************************
    instr_decoder u_decoder (
        .instr   (instr),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .decoded (decoded)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .reset_n (reset_n),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .we      (wb_we),
        .waddr   (ex_wb_q.dest),
        .wdata   (ex_wb_q.result)
    );

    pipe_stage_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk     (clk),
        .reset_n (reset_n),
        .load    (instr_valid),
        .bubble  (flush || !instr_valid),
        .d       (decoded),
        .q       (id_ex_q),
        .q_valid (id_ex_valid)
    );

    // ***********************************************************
    // Execute and writeback
    // ***********************************************************
    execute_stage u_execute (
        .clk          (clk),
        .reset_n      (reset_n),
        .id_ex        (id_ex_q),
        .id_ex_valid  (id_ex_valid),
        .ex_wb        (ex_wb_q),
        .ex_wb_valid  (ex_wb_valid),
        .result       (ex_result),
        .result_valid (ex_result_valid)
    );

    // A halted entry is held so done stays up.
    pipe_stage_reg #(.payload_t(ex_wb_t)) ex_wb_reg (
        .clk     (clk),
        .reset_n (reset_n),
        .load    (ex_result_valid),
        .bubble  (!ex_result_valid && !halt_in_wb),
        .d       (ex_result),
        .q       (ex_wb_q),
        .q_valid (ex_wb_valid)
    );

    assign halt_in_wb = ex_wb_valid && ex_wb_q.is_halt;
    assign wb_we      = ex_wb_valid && ex_wb_q.reg_write;
    assign out_port   = ex_wb_q.result;
    assign out_valid  = ex_wb_valid && ex_wb_q.is_wwd;
    assign done       = halt_in_wb;

endmodule

`default_nettype wire

// File: exec_slice_chk.sv
`timescale 1ns/1ps
`default_nettype none

module exec_slice_chk (
    input logic clk,
    input logic reset_n,
    input logic out_valid,
    input logic done
);

    int fail_count = 0;

    // ***********************************************************
    // Output protocol
    // ***********************************************************

    // Quiet while in reset and one cycle after.
    assert property (@(posedge clk) ($past(reset_n) || $past(reset_n, 2)) |-> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high during reset or the cycle after it");
        end

    assert property (@(posedge clk) disable iff (reset_n) done |=> done)
        else begin
            fail_count++;
            $error("done fell without a reset");
        end

    // Nothing leaves the pipeline behind the HLT.
    assert property (@(posedge clk) disable iff (reset_n) done |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high after the pipeline halted");
        end

endmodule

`default_nettype wire

// File: exec_slice_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module exec_slice_tb;

    import isa_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 5;

    typedef struct packed {
        logic [`WORD_SIZE-1:0] word;
        logic                  valid;
        logic                  flush;
        logic                  check;   // A WWD that must reach out_port.
        logic                  no_gap;  // Issued right behind the previous entry.
    } stim_t;

    typedef struct packed {
        logic [`WORD_SIZE-1:0] value;
        logic [15:0]           entry;
    } expect_t;

    logic                  clk;
    logic                  reset_n;
    logic [`WORD_SIZE-1:0] instr;
    logic                  instr_valid;
    logic                  flush;
    logic [`WORD_SIZE-1:0] out_port;
    logic                  out_valid;
    logic                  done;

    stim_t                 stim_q[$];
    expect_t               expect_q[$];
    logic [`WORD_SIZE-1:0] model_regs [`NUM_REGS];
    logic [31:0]           lfsr;
    logic                  halt_issued;
    logic                  done_seen;
    logic                  table_ready;
    int                    test_count;
    int                    error_count;

    exec_slice_top UUT (
        .clk         (clk),
        .reset_n     (reset_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .flush       (flush),
        .out_port    (out_port),
        .out_valid   (out_valid),
        .done        (done)
    );

    bind exec_slice_top exec_slice_chk chk (
        .clk       (clk),
        .reset_n   (reset_n),
        .out_valid (out_valid),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ***********************************************************
    // Helpers
    // ***********************************************************
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]}; // Taps 32,22,2,1.
    endfunction

    task automatic draw_bits(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic logic [15:0] encode_r(input logic [5:0] fn, input int rs,
                                             input int rt, input int rd);
        return {OP_ALU_R, 2'(rs), 2'(rt), 2'(rd), fn};
    endfunction

    function automatic logic [15:0] encode_i(input logic [3:0] op, input int rs,
                                             input int rt, input logic [7:0] imm);
        return {op, 2'(rs), 2'(rt), imm};
    endfunction

    task automatic add_entry(input logic [15:0] word, input int is_valid, input int is_flush,
                             input int check, input int no_gap);
        stim_t e;
        e.word   = word;
        e.valid  = (is_valid != 0);
        e.flush  = (is_flush != 0);
        e.check  = (check != 0);
        e.no_gap = (no_gap != 0);
        stim_q.push_back(e);
    endtask

    // ISA reference model, run as each entry is issued.
    task automatic model_issue(input stim_t e, input int idx);
        logic [3:0]            op;
        logic [5:0]            fn;
        logic [7:0]            imm;
        logic [`WORD_SIZE-1:0] a;
        logic [`WORD_SIZE-1:0] b;
        int                    rt;
        int                    rd;
        op  = e.word[15:12];
        fn  = e.word[5:0];
        imm = e.word[7:0];
        rt  = int'(e.word[9:8]);
        rd  = int'(e.word[7:6]);
        a   = model_regs[e.word[11:10]];
        b   = model_regs[rt];
        if (e.valid && !e.flush && !halt_issued) begin
            case (op)
                4'd4: model_regs[rt] = a + {{8{imm[7]}}, imm};
                4'd5: model_regs[rt] = a | {8'h00, imm};
                4'd6: model_regs[rt] = {imm, 8'h00};
                4'd15: begin
                    case (fn)
                        6'd0: model_regs[rd] = a + b;
                        6'd1: model_regs[rd] = a - b;
                        6'd2: model_regs[rd] = a & b;
                        6'd3: model_regs[rd] = a | b;
                        6'd4: model_regs[rd] = ~a;
                        6'd5: model_regs[rd] = 16'h0000 - a;
                        6'd6: model_regs[rd] = {a[14:0], 1'b0};
                        6'd7: model_regs[rd] = {a[15], a[15:1]};
                        6'd28: if (e.check) expect_q.push_back({a, 16'(idx)});
                        6'd29: halt_issued = 1'b1;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    endtask

    task automatic issue(input stim_t e, input int idx);
        @(posedge clk);
        #DRIVE_DELAY;
        instr       = e.word;
        instr_valid = e.valid;
        flush       = e.flush;
        model_issue(e, idx);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
        instr       = '0;
        instr_valid = 1'b0;
        flush       = 1'b0;
    endtask

    // ***********************************************************
    // Stimulus table
    // ***********************************************************
    task automatic build_table();
        // r1 = 1234, r2 = F0A5, r3 = 8001.
        add_entry(encode_i(OP_LHI, 0, 1, 8'h12), 1, 0, 0, 0);
        add_entry(encode_i(OP_ORI, 1, 1, 8'h34), 1, 0, 0, 0);
        add_entry(encode_i(OP_LHI, 0, 2, 8'hF0), 1, 0, 0, 0);
        add_entry(encode_i(OP_ORI, 2, 2, 8'hA5), 1, 0, 0, 0);
        add_entry(encode_i(OP_LHI, 0, 3, 8'h80), 1, 0, 0, 0);
        add_entry(encode_i(OP_ORI, 3, 3, 8'h01), 1, 0, 0, 0);
        add_entry(encode_r(FN_WWD, 1, 0, 0), 1, 0, 1, 0);
        add_entry(encode_r(FN_ADD, 1, 2, 0), 1, 0, 0, 0);
        add_entry(encode_r(FN_WWD, 0, 0, 0), 1, 0, 1, 0);
        add_entry(encode_r(FN_SUB, 1, 2, 0), 1, 0, 0, 0);
        add_entry(encode_r(FN_WWD, 0, 0, 0), 1, 0, 1, 0);
        add_entry(encode_r(FN_AND, 1, 2, 0), 1, 0, 0, 0);
        add_entry(encode_r(FN_WWD, 0, 0, 0), 1, 0, 1, 0);
        add_entry(encode_r(FN_ORR, 1, 2, 0), 1, 0, 0, 0);
        add_entry(encode_r(FN_WWD, 0, 0, 0), 1, 0, 1, 0);
        add_entry(encode_r(FN_NOT, 1, 0, 0), 1, 0, 0, 0);
        add_entry(encode_r(FN_WWD, 0, 0, 0), 1, 0, 1, 0);
        add_entry(encode_r(FN_TCP, 2, 0, 0), 1, 0, 0, 0);
        add_entry(encode_r(FN_WWD, 0, 0, 0), 1, 0, 1, 0);
        add_entry(encode_r(FN_SHL, 3, 0, 0), 1, 0, 0, 0);
        add_entry(encode_r(FN_WWD, 0, 0, 0), 1, 0, 1, 0);
        add_entry(encode_r(FN_SHR, 3, 0, 0), 1, 0, 0, 0);   // Negative operand.
        add_entry(encode_r(FN_WWD, 0, 0, 0), 1, 0, 1, 0);
        add_entry(encode_i(OP_ADI, 1, 0, 8'hF0), 1, 0, 0, 0);
        add_entry(encode_r(FN_WWD, 0, 0, 0), 1, 0, 1, 0);
        // Dependent chain with no idle cycles.
        add_entry(encode_r(FN_ADD, 1, 2, 0), 1, 0, 0, 0);
        add_entry(encode_r(FN_SUB, 1, 0, 3), 1, 0, 0, 1);
        add_entry(encode_r(FN_ORR, 3, 0, 2), 1, 0, 0, 1);
        add_entry(encode_r(FN_WWD, 3, 0, 0), 1, 0, 1, 1);
        add_entry(encode_r(FN_WWD, 2, 0, 0), 1, 0, 1, 1);
        // Flushed and invalid slots.
        add_entry(encode_i(OP_LHI, 0, 1, 8'h55), 1, 1, 0, 0);
        add_entry(encode_r(FN_ADD, 2, 3, 1), 0, 0, 0, 1);
        add_entry(encode_r(FN_WWD, 1, 0, 0), 1, 0, 1, 1);
        add_entry(encode_r(FN_WWD, 2, 0, 0), 1, 1, 0, 0);
        add_entry(encode_r(FN_HLT, 0, 0, 0), 1, 0, 0, 0);
        add_entry(encode_r(FN_WWD, 1, 0, 0), 1, 0, 0, 1);
    endtask

    // ***********************************************************
    // Output monitor
    // ***********************************************************
    always @(negedge clk) begin
        expect_t head;
        if (!reset_n) begin
            if (out_valid) begin
                if (expect_q.size() == 0) begin
                    error_count++;
                    $display("ERROR at %0t: out_valid high with no WWD output expected", $time);
                end else begin
                    head = expect_q.pop_front();
                    test_count++;
                    if (out_port !== head.value) begin
                        error_count++;
                        $display("FAILED at %0t: out_port = %h, expected %h",
                                 $time, out_port, head.value);
                    end else begin
                        $display("test %0d (entry %0d): out_port = %h ok",
                                 test_count, head.entry, out_port);
                    end
                end
            end
            if (done && !halt_issued) begin
                error_count++;
                $display("ERROR at %0t: done rose before any HLT was issued", $time);
            end
            if (done_seen && !done) begin
                error_count++;
                $display("ERROR at %0t: done fell after it had risen", $time);
            end
            done_seen = done_seen || (done === 1'b1);
        end
    end

    initial begin
        wait (table_ready);
        repeat (stim_q.size() * 5 + 50) @(posedge clk);
        $display("ERROR: watchdog expired before the stimulus table finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ***********************************************************
    // Main sequence
    // ***********************************************************
    initial begin
        int idle;
        reset_n     = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        flush       = 1'b0;
        lfsr        = 32'd90286;
        halt_issued = 1'b0;
        done_seen   = 1'b0;
        table_ready = 1'b0;
        test_count  = 0;
        error_count = 0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        build_table();
        table_ready = 1'b1;

        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        reset_n = 1'b0;

        foreach (stim_q[i]) begin
            if (!stim_q[i].no_gap) begin
                draw_bits(2, idle);   // 0 to 3 idle cycles.
                repeat (idle) idle_cycle();
            end
            issue(stim_q[i], i);
        end
        repeat (10) idle_cycle();

        test_count++;
        if (done !== 1'b1) begin
            error_count++;
            $display("FAILED at %0t: done = %b, expected 1", $time, done);
        end else begin
            $display("test %0d: done held high after HLT ok", test_count);
        end
        if (expect_q.size() != 0) begin
            error_count++;
            $display("ERROR: %0d expected WWD outputs never appeared", expect_q.size());
        end
        if (UUT.chk.fail_count != 0) begin
            error_count++;
            $display("ERROR: %0d assertion failures in the bound checker", UUT.chk.fail_count);
        end
        $display("tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
instr_decoder.sv
reg_file.sv
pipe_stage_reg.sv
execute_stage.sv
exec_slice_top.sv
exec_slice_chk.sv
exec_slice_tb.sv

// File: Makefile
TOP = exec_slice_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
